// File: project.f
lcd_pkg.sv
tile_pkg.sv
command_lut.sv
lcd_write_strobe.sv
draw_ctrl.sv
tile_lcd_top.sv
tb_tile_lcd_assert.sv
tb_tile_lcd.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tile_lcd
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q -F "$(PASS_MSG)" $(LOG); then echo "test did not complete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_tile_lcd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_lcd;

    import lcd_pkg::*;
    import tile_pkg::*;

    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;
    localparam int TIMEOUT        = 2000 * (2 + WR_LOW_CYCLES + WR_HIGH_CYCLES);  // cycles per wait

    logic       clk;
    logic       nrst;
    logic       req;
    tile_req_t  tile;
    logic       ack;
    logic [7:0] lcd_d;
    logic       lcd_dcx;
    logic       lcd_wrx;

    lcd_byte_t  got_q[$];  // bytes seen on the bus
    lcd_byte_t  exp_q[$];
    int         seed;
    int         r;

    tile_lcd_top #(
        .WR_LOW_CYCLES  (WR_LOW_CYCLES),
        .WR_HIGH_CYCLES (WR_HIGH_CYCLES)
    ) u_tile_lcd_top (
        .clk     (clk),
        .nrst    (nrst),
        .req     (req),
        .tile    (tile),
        .ack     (ack),
        .lcd_d   (lcd_d),
        .lcd_dcx (lcd_dcx),
        .lcd_wrx (lcd_wrx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // the panel latches on the rising edge of wrx
    always @(posedge lcd_wrx) begin
        if (nrst === 1'b1) begin
            got_q.push_back('{d: lcd_d, dcx: lcd_dcx});
        end
    end

    always @(negedge clk) begin
        if (u_tile_lcd_top.u_tile_lcd_assert.fail_count != 0) begin
            stop_with_failure("a bus or handshake assertion failed");
        end
    end

    // ====================
    // expected stream

    function automatic logic [15:0] expected_colour(input logic [2:0] code);
        logic [15:0] c;
        case (code)
            3'd1:    c = 16'h901E;
            3'd2:    c = 16'h6815;
            3'd3:    c = 16'hF800;
            3'd4:    c = 16'h0814;
            default: c = 16'hFFFF;  // code 0 and the unused codes are white
        endcase
        return c;
    endfunction

    task automatic expect_cmd(input logic [7:0] d);
        exp_q.push_back('{d: d, dcx: 1'b0});
    endtask

    task automatic expect_data(input logic [7:0] d);
        exp_q.push_back('{d: d, dcx: 1'b1});
    endtask

    task automatic expect_word(input logic [15:0] w);
        expect_data(w[15:8]);  // high byte goes first
        expect_data(w[7:0]);
    endtask

    task automatic expect_init();
        expect_cmd(8'h01);
        expect_cmd(8'h28);
        expect_cmd(8'h3A);
        expect_data(8'h55);
        expect_cmd(8'h11);
        expect_cmd(8'h29);
    endtask

    task automatic expect_tile(input tile_req_t t);
        logic [15:0] colour;
        int          i;
        colour = expected_colour(t.obj_code);
        expect_cmd(8'h2A);
        expect_word(16'(t.x) * 16'd20);
        expect_word((16'(t.x) + 16'd1) * 16'd20);
        expect_cmd(8'h2B);
        expect_word(16'(t.y) * 16'd20);
        expect_word((16'(t.y) + 16'd1) * 16'd20);
        expect_cmd(8'h2C);
        for (i = 0; i < 400; i++) begin
            expect_word(colour);
        end
    endtask

    // ====================
    // checks and waits

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_stream(input string name);
        int i;
        assert (got_q.size() == exp_q.size())
            else stop_with_failure($sformatf("[FAIL] %s byte count: expected %0d, actual %0d",
                                             name, exp_q.size(), got_q.size()));
        for (i = 0; i < exp_q.size(); i++) begin
            assert (got_q[i] === exp_q[i])
                else stop_with_failure($sformatf("[FAIL] %s byte %0d: expected %h/%b, actual %h/%b",
                                                 name, i, exp_q[i].d, exp_q[i].dcx,
                                                 got_q[i].d, got_q[i].dcx));
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic wait_ack(input logic level, input string name);
        int n;
        n = 0;
        while (ack !== level) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_with_failure($sformatf("timeout in %s, ack never went to %0b", name, level));
            end
        end
    endtask

    task automatic wait_bytes(input int count, input string name);
        int n;
        n = 0;
        while (got_q.size() < count) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                stop_with_failure($sformatf("timeout in %s, only %0d bytes reached the bus",
                                            name, got_q.size()));
            end
        end
    endtask

    // ====================
    // host side

    task automatic finish_tile(input tile_req_t t, input string name);
        expect_tile(t);
        wait_ack(1'b1, name);
        compare_stream(name);
        @(posedge clk);
        req <= 1'b0;
        wait_ack(1'b0, name);
    endtask

    task automatic run_tile(input tile_req_t t, input string name);
        @(posedge clk);
        tile <= t;
        req  <= 1'b1;
        finish_tile(t, name);
    endtask

    initial begin
        tile_req_t t;
        int        k;
        seed = 32'ha596_25bc;
        nrst = 1'b0;
        req  = 1'b0;
        tile = '0;
        repeat (10) @(posedge clk);
        nrst <= 1'b1;

        // this request goes up while the init sequence is still running
        t = '{x: 4'd3, y: 4'd5, obj_code: 3'd1};
        @(posedge clk);
        tile <= t;
        req  <= 1'b1;
        wait_bytes(6, "init");
        expect_init();
        compare_stream("init");
        finish_tile(t, "tile_during_init");

        run_tile('{x: 4'd0, y: 4'd0, obj_code: 3'd0}, "corner_origin");
        run_tile('{x: 4'd11, y: 4'd11, obj_code: 3'd4}, "corner_far");
        run_tile('{x: 4'd7, y: 4'd2, obj_code: 3'd2}, "code_2");
        run_tile('{x: 4'd1, y: 4'd9, obj_code: 3'd3}, "code_3");

        for (k = 0; k < 8; k++) begin
            r = $random(seed);
            t.x = 4'($unsigned(r) % 12);
            r = $random(seed);
            t.y = 4'($unsigned(r) % 12);
            r = $random(seed);
            t.obj_code = r[2:0];
            run_tile(t, $sformatf("random_%0d", k));
            r = $random(seed);
            repeat (r[2:0]) @(posedge clk);  // idle gap with req low
        end

        repeat (20) @(posedge clk);
        if (u_tile_lcd_top.u_tile_lcd_assert.fail_count != 0) begin
            stop_with_failure("a bus or handshake assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb_tile_lcd_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tile_lcd_assert #(
    parameter int WR_LOW_CYCLES  = 2,
    parameter int WR_HIGH_CYCLES = 2
) (
    input wire logic       clk,
    input wire logic       nrst,
    input wire logic       req,
    input wire logic       ack,
    input wire logic [7:0] lcd_d,
    input wire logic       lcd_dcx,
    input wire logic       lcd_wrx
);

    int fail_count = 0;  // failed checks so far

    // ====================
    // handshake

    a_reset_values: assert property (@(posedge clk) !nrst |=> nrst || (lcd_wrx && !ack))
        else begin $error("wrx low or ack high during reset"); fail_count++; end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!nrst) $rose(ack) |-> req)
        else begin $error("ack rose while req was low"); fail_count++; end

    // ack rises right after the high phase of the last pixel byte
    a_ack_after_last: assert property (@(posedge clk) disable iff (!nrst)
                                       $rose(ack) |-> lcd_wrx && lcd_dcx &&
                                                      $past(lcd_wrx, WR_HIGH_CYCLES) &&
                                                      !$past(lcd_wrx, WR_HIGH_CYCLES + 1))
        else begin $error("ack rose before the last byte"); fail_count++; end

    a_ack_held: assert property (@(posedge clk) disable iff (!nrst) ack && req |=> ack)
        else begin $error("ack dropped while req was high"); fail_count++; end

    a_ack_falls: assert property (@(posedge clk) disable iff (!nrst) $fell(ack) |-> !$past(req))
        else begin $error("ack fell before req fell"); fail_count++; end

    // ====================
    // write strobe

    a_wrx_low_width: assert property (@(posedge clk) disable iff (!nrst)
                                      $rose(lcd_wrx) |-> !$past(lcd_wrx, WR_LOW_CYCLES) &&
                                                         $past(lcd_wrx, WR_LOW_CYCLES + 1))
        else begin $error("wrx low phase has the wrong length"); fail_count++; end

    a_bus_stable: assert property (@(posedge clk) disable iff (!nrst)
                                   !$past(lcd_wrx) |-> $stable({lcd_d, lcd_dcx}))
        else begin $error("d or dcx changed while wrx was low"); fail_count++; end

endmodule

bind tile_lcd_top tb_tile_lcd_assert #(
    .WR_LOW_CYCLES  (WR_LOW_CYCLES),
    .WR_HIGH_CYCLES (WR_HIGH_CYCLES)
) u_tile_lcd_assert (
    .clk     (clk),
    .nrst    (nrst),
    .req     (req),
    .ack     (ack),
    .lcd_d   (lcd_d),
    .lcd_dcx (lcd_dcx),
    .lcd_wrx (lcd_wrx)
);

`default_nettype wire

// File: tile_lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tile_lcd_top #(
    parameter int WR_LOW_CYCLES  = 2,
    parameter int WR_HIGH_CYCLES = 2
) (
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire logic                req,
    input  wire tile_pkg::tile_req_t tile,
    output logic                     ack,
    output logic [7:0]               lcd_d,
    output logic                     lcd_dcx,
    output logic                     lcd_wrx
);

    import lcd_pkg::*;
    import tile_pkg::*;

    update_t   mode;
    tile_req_t tile_q;
    lcd_byte_t cur;
    logic      pause;
    logic      cmd_finished;
    logic      start;
    logic      done;

    // ====================
    // control

    draw_ctrl u_draw_ctrl (
        .clk          (clk),
        .nrst         (nrst),
        .req          (req),
        .tile         (tile),
        .pause        (pause),
        .cmd_finished (cmd_finished),
        .done         (done),
        .ack          (ack),
        .mode         (mode),
        .tile_q       (tile_q),
        .start        (start)
    );

    // ====================
    // datapath

    command_lut u_command_lut (
        .clk          (clk),
        .nrst         (nrst),
        .mode         (mode),
        .tile         (tile_q),
        .cur          (cur),
        .pause        (pause),
        .cmd_finished (cmd_finished)
    );

    lcd_write_strobe #(
        .WR_LOW_CYCLES  (WR_LOW_CYCLES),
        .WR_HIGH_CYCLES (WR_HIGH_CYCLES)
    ) u_lcd_write_strobe (
        .clk     (clk),
        .nrst    (nrst),
        .start   (start),
        .byte_in (cur),
        .lcd_d   (lcd_d),
        .lcd_dcx (lcd_dcx),
        .lcd_wrx (lcd_wrx),
        .done    (done)
    );

endmodule

`default_nettype wire

// File: draw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module draw_ctrl (
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire logic                req,
    input  wire tile_pkg::tile_req_t tile,
    input  wire logic                pause,
    input  wire logic                cmd_finished,
    input  wire logic                done,
    output logic                     ack,
    output lcd_pkg::update_t         mode,
    output tile_pkg::tile_req_t      tile_q,
    output logic                     start
);

    import lcd_pkg::*;

    typedef enum logic [2:0] {
        INIT_STEP,
        INIT_WAIT,
        IDLE,
        DRAW_STEP,
        DRAW_WAIT,
        ACK_HIGH
    } state_t;

    state_t state;
    logic   init_done;
    logic   take_req;

    // requests wait here until the panel init has finished
    assign take_req = (state == IDLE) && init_done && req;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= IDLE;
            init_done <= 1'b0;
            start     <= 1'b0;
            ack       <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                IDLE: begin
                    if (!init_done) state <= INIT_STEP;
                    else if (take_req) state <= DRAW_STEP;
                end
                INIT_STEP: begin
                    if (!pause) begin
                        state <= INIT_WAIT;
                        start <= 1'b1;
                    end
                end
                INIT_WAIT: begin
                    if (done && cmd_finished) begin
                        init_done <= 1'b1;
                        state     <= IDLE;
                    end else if (done) begin
                        state <= INIT_STEP;
                    end
                end
                DRAW_STEP: begin
                    if (!pause) begin
                        state <= DRAW_WAIT;
                        start <= 1'b1;
                    end
                end
                DRAW_WAIT: begin
                    if (done && cmd_finished) begin
                        ack   <= 1'b1;  // last pixel byte is on the panel
                        state <= ACK_HIGH;
                    end else if (done) begin
                        state <= DRAW_STEP;
                    end
                end
                ACK_HIGH: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            tile_q <= tile;
        end
    end

    always_comb begin
        case (state)
            INIT_STEP: mode = SET_I;
            INIT_WAIT: mode = SEND_I;
            DRAW_STEP: mode = SET;
            DRAW_WAIT: mode = SEND;
            default:   mode = lcd_pkg::IDLE;  // clears the sequencer step
        endcase
    end

endmodule

`default_nettype wire

// File: lcd_write_strobe.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_write_strobe #(
    parameter int WR_LOW_CYCLES  = 2,
    parameter int WR_HIGH_CYCLES = 2
) (
    input  wire logic               clk,
    input  wire logic               nrst,
    input  wire logic               start,
    input  wire lcd_pkg::lcd_byte_t byte_in,
    output logic [7:0]              lcd_d,
    output logic                    lcd_dcx,
    output logic                    lcd_wrx,
    output logic                    done
);

    import lcd_pkg::*;

    localparam int MAX_PHASE = (WR_LOW_CYCLES > WR_HIGH_CYCLES) ? WR_LOW_CYCLES : WR_HIGH_CYCLES;
    localparam int CNT_W     = $clog2(MAX_PHASE + 1);

    lcd_byte_t        byte_q;
    logic             busy;
    logic [CNT_W-1:0] cnt;  // cycles left in the current phase

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lcd_wrx <= 1'b1;
            busy    <= 1'b0;
            cnt     <= '0;
        end else if (start) begin
            lcd_wrx <= 1'b0;
            busy    <= 1'b1;
            cnt     <= CNT_W'(WR_LOW_CYCLES - 1);
        end else if (busy) begin
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (!lcd_wrx) begin
                lcd_wrx <= 1'b1;  // rising edge, the panel latches here
                cnt     <= CNT_W'(WR_HIGH_CYCLES - 1);
            end else begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            byte_q <= byte_in;
        end
    end

    assign lcd_d   = byte_q.d;
    assign lcd_dcx = byte_q.dcx;
    assign done    = busy && lcd_wrx && (cnt == '0);

endmodule

`default_nettype wire

// File: command_lut.sv
`timescale 1ns/1ps
`default_nettype none

module command_lut (
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire lcd_pkg::update_t    mode,
    input  wire tile_pkg::tile_req_t tile,
    output lcd_pkg::lcd_byte_t       cur,
    output logic                     pause,
    output logic                     cmd_finished
);

    import lcd_pkg::*;
    import tile_pkg::*;

    localparam logic [15:0] INIT_PAUSE = 16'd7;  // idle cycles after SWRESET and SLPOUT
    localparam logic [15:0] PIX_BYTES  = 16'd2 * TILE_PIX * TILE_PIX;

    logic [3:0]  cmd_num;
    logic [3:0]  next_cmd_num;
    logic [15:0] count;  // delay cycles in init, pixel bytes sent in a tile
    logic [15:0] next_count;
    logic [15:0] sc;
    logic [15:0] ec;
    logic [15:0] sp;
    logic [15:0] ep;
    logic [15:0] colour;
    logic        init_mode;
    logic        draw_mode;

    assign init_mode = (mode == SET_I) || (mode == SEND_I);
    assign draw_mode = (mode == SET) || (mode == SEND);

    // tile corners in panel coordinates
    assign sc = {12'd0, tile.x} * TILE_PIX;
    assign ec = ({12'd0, tile.x} + 16'd1) * TILE_PIX;
    assign sp = {12'd0, tile.y} * TILE_PIX;
    assign ep = ({12'd0, tile.y} + 16'd1) * TILE_PIX;

    assign colour = obj_colour(tile.obj_code);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_num <= 4'd0;
            count   <= 16'd0;
        end else begin
            cmd_num <= next_cmd_num;
            count   <= next_count;
        end
    end

    // ====================
    // step and counter update

    always_comb begin
        next_cmd_num = cmd_num;
        next_count   = count;
        pause        = 1'b0;
        case (mode)
            IDLE: begin
                next_cmd_num = 4'd0;  // every sequence starts from step zero
                next_count   = 16'd0;
            end
            SET_I: begin
                if ((cmd_num == 4'd1 || cmd_num == 4'd5) && count < INIT_PAUSE) begin
                    pause      = 1'b1;
                    next_count = count + 16'd1;
                end else begin
                    next_cmd_num = cmd_num + 4'd1;
                    next_count   = 16'd0;
                end
            end
            SET: begin
                case (cmd_num)
                    4'd12: begin
                        next_cmd_num = 4'd13;
                        next_count   = count + 16'd1;
                    end
                    4'd13: begin
                        next_cmd_num = 4'd12;
                        next_count   = count + 16'd1;
                    end
                    default: next_cmd_num = cmd_num + 4'd1;
                endcase
            end
            default: next_cmd_num = cmd_num;  // hold while the byte is on the bus
        endcase
    end

    // last init byte, or the low byte of the last pixel
    assign cmd_finished = ((mode == SEND_I) && (cmd_num == 4'd6)) ||
                          ((mode == SEND) && (cmd_num == 4'd13) &&
                           (count == PIX_BYTES - 16'd1));

    // ====================
    // byte decode from the registered step

    always_comb begin
        cur = '{d: 8'h00, dcx: 1'b0};
        if (init_mode) begin
            case (cmd_num)
                4'd1:    cur = '{d: CMD_SWRESET, dcx: 1'b0};
                4'd2:    cur = '{d: CMD_DISPOFF, dcx: 1'b0};
                4'd3:    cur = '{d: CMD_COLMOD, dcx: 1'b0};
                4'd4:    cur = '{d: COLMOD_565, dcx: 1'b1};
                4'd5:    cur = '{d: CMD_SLPOUT, dcx: 1'b0};
                4'd6:    cur = '{d: CMD_DISPON, dcx: 1'b0};
                default: cur = '{d: 8'h00, dcx: 1'b0};
            endcase
        end else if (draw_mode) begin
            case (cmd_num)
                4'd1:    cur = '{d: CMD_CASET, dcx: 1'b0};
                4'd2:    cur = '{d: sc[15:8], dcx: 1'b1};
                4'd3:    cur = '{d: sc[7:0], dcx: 1'b1};
                4'd4:    cur = '{d: ec[15:8], dcx: 1'b1};
                4'd5:    cur = '{d: ec[7:0], dcx: 1'b1};
                4'd6:    cur = '{d: CMD_PASET, dcx: 1'b0};
                4'd7:    cur = '{d: sp[15:8], dcx: 1'b1};
                4'd8:    cur = '{d: sp[7:0], dcx: 1'b1};
                4'd9:    cur = '{d: ep[15:8], dcx: 1'b1};
                4'd10:   cur = '{d: ep[7:0], dcx: 1'b1};
                4'd11:   cur = '{d: CMD_RAMWR, dcx: 1'b0};
                4'd12:   cur = '{d: colour[15:8], dcx: 1'b1};
                4'd13:   cur = '{d: colour[7:0], dcx: 1'b1};
                default: cur = '{d: 8'h00, dcx: 1'b0};
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tile_pkg.sv
`default_nettype none

package tile_pkg;

    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
        logic [2:0] obj_code;
    } tile_req_t;

    localparam logic [15:0] TILE_PIX = 16'd20;  // tile edge in pixels

    // RGB565 colour of each object code, unknown codes draw white
    function automatic logic [15:0] obj_colour(input logic [2:0] code);
        logic [15:0] c;
        case (code)
            3'd1:    c = 16'h901E;
            3'd2:    c = 16'h6815;
            3'd3:    c = 16'hF800;
            3'd4:    c = 16'h0814;
            default: c = 16'hFFFF;
        endcase
        return c;
    endfunction

endpackage

`default_nettype wire

// File: lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // sequencer modes, driven by the control FSM
    typedef enum logic [2:0] {
        IDLE,
        SET_I,   // advance one init step
        SEND_I,  // hold the init byte while it is on the bus
        SET,     // advance one tile step
        SEND     // hold the tile byte while it is on the bus
    } update_t;

    // dcx is low for a command byte and high for a data byte
    typedef struct packed {
        logic [7:0] d;
        logic       dcx;
    } lcd_byte_t;

    localparam logic [7:0] CMD_SWRESET = 8'h01;
    localparam logic [7:0] CMD_DISPOFF = 8'h28;
    localparam logic [7:0] CMD_COLMOD  = 8'h3A;
    localparam logic [7:0] CMD_SLPOUT  = 8'h11;
    localparam logic [7:0] CMD_DISPON  = 8'h29;
    localparam logic [7:0] CMD_CASET   = 8'h2A;
    localparam logic [7:0] CMD_PASET   = 8'h2B;
    localparam logic [7:0] CMD_RAMWR   = 8'h2C;
    localparam logic [7:0] COLMOD_565  = 8'h55;  // 16 bits per pixel

endpackage

`default_nettype wire
